// ==== design/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////
// Datapath
////////////////////

// Machine word, also the instruction width
`define DATA_W 32

////////////////////
// Memories
////////////////////

// Instruction memory, in words
`define IMEM_DEPTH 64

// Data memory, in words
`define DMEM_DEPTH 64

////////////////////
// Encodings
////////////////////

// R-type with rd = 0, so it never reaches the register file
`define NOP_WORD 32'h0000_0000

`endif

// ==== design/isaPkg.sv ====
`include "mips_defs.svh"

package isaPkg;

    ////////////////////
    // Field types
    ////////////////////
    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [4:0]         regAddr_t;
    typedef logic [15:0]        imm_t;

    ////////////////////
    // Encodings
    ////////////////////
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // Funct field of R-type instructions
    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    // Coarse request from the decoder, refined in execute
    typedef enum logic [1:0] {
        CLS_ADD,
        CLS_SUB,
        CLS_FUNCT
    } aluClass_e;

endpackage

// ==== design/pipePkg.sv ====
package pipePkg;

    ////////////////////
    // Control bundles
    ////////////////////

    // Used in execute
    typedef struct packed {
        logic              aluSrc;
        isaPkg::aluClass_e aluClass;
        logic              regDst;
    } exCtrl_t;

    // Used in memory
    typedef struct packed {
        logic branch;
        logic memRead;
        logic memWrite;
    } memCtrl_t;

    // Used in writeback
    typedef struct packed {
        logic memToReg;
        logic regWrite;
    } wbCtrl_t;

    ////////////////////
    // Stage registers
    ////////////////////
    typedef struct packed {
        isaPkg::word_t pc4;
        isaPkg::word_t instr;
    } ifId_t;

    typedef struct packed {
        exCtrl_t          exCtrl;
        memCtrl_t         memCtrl;
        wbCtrl_t          wbCtrl;
        isaPkg::word_t    pc4;
        isaPkg::word_t    rsData;
        isaPkg::word_t    rtData;
        isaPkg::word_t    immExt;
        isaPkg::regAddr_t rt;
        isaPkg::regAddr_t rd;
    } idEx_t;

    typedef struct packed {
        memCtrl_t         memCtrl;
        wbCtrl_t          wbCtrl;
        isaPkg::word_t    branchTarget;
        logic             zero;
        isaPkg::word_t    aluResult;
        isaPkg::word_t    storeData;
        isaPkg::regAddr_t destReg;
    } exMem_t;

    typedef struct packed {
        wbCtrl_t          wbCtrl;
        isaPkg::word_t    aluResult;
        isaPkg::word_t    loadData;
        isaPkg::regAddr_t destReg;
    } memWb_t;

    // Redirect from memory back to fetch
    typedef struct packed {
        logic          taken;
        isaPkg::word_t target;
    } branch_t;

endpackage

// ==== design/fetchStage.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module fetchStage (
    input  logic                           i_clk,
    input  logic                           i_rstN,
    input  pipePkg::branch_t               i_branch,
    input  logic                           i_progWe,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] i_progAddr,
    input  isaPkg::word_t                  i_progData,
    output pipePkg::ifId_t                 o_ifId
);

    localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

    isaPkg::word_t imem [`IMEM_DEPTH];
    isaPkg::word_t pc;
    isaPkg::word_t pc4;
    isaPkg::word_t pcNext;
    isaPkg::word_t instr;

    ////////////////////
    // Next PC
    ////////////////////
    assign pc4    = pc + 32'd4;
    assign pcNext = i_branch.taken ? i_branch.target : pc4;

    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    ////////////////////
    // Instruction memory
    ////////////////////

    // Loader only writes while the core is held in reset
    always_ff @(posedge i_clk) begin
        if (!i_rstN && i_progWe) begin
            imem[i_progAddr] <= i_progData;
        end
    end

    assign instr = imem[pc[IMEM_AW+1:2]];

    // IF/ID register
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_ifId <= '{pc4: '0, instr: `NOP_WORD};
        end else begin
            o_ifId <= '{pc4: pc4, instr: instr};
        end
    end

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module decodeStage (
    input  logic              i_clk,
    input  logic              i_rstN,
    input  pipePkg::ifId_t    i_ifId,
    input  pipePkg::memWb_t   i_memWb,
    output pipePkg::idEx_t    o_idEx,
    output logic              o_wbValid,
    output isaPkg::regAddr_t  o_wbReg,
    output isaPkg::word_t     o_wbData
);

    localparam int NUM_REGS = 32;

    isaPkg::opcode_e   opcode;
    isaPkg::regAddr_t  rs;
    isaPkg::regAddr_t  rt;
    isaPkg::regAddr_t  rd;
    isaPkg::imm_t      imm;
    isaPkg::word_t     immExt;
    pipePkg::exCtrl_t  ctrlEx;
    pipePkg::memCtrl_t ctrlMem;
    pipePkg::wbCtrl_t  ctrlWb;
    isaPkg::word_t     regs [NUM_REGS];
    isaPkg::word_t     wbData;
    logic              wbEn;

    assign opcode = isaPkg::opcode_e'(i_ifId.instr[31:26]);
    assign rs     = i_ifId.instr[25:21];
    assign rt     = i_ifId.instr[20:16];
    assign rd     = i_ifId.instr[15:11];
    assign imm    = i_ifId.instr[15:0];
    assign immExt = {{(`DATA_W-16){imm[15]}}, imm};

    ////////////////////
    // Control decoder
    ////////////////////
    always_comb begin
        ctrlEx  = '0;
        ctrlMem = '0;
        ctrlWb  = '0;
        case (opcode)
            isaPkg::OP_RTYPE: begin
                ctrlEx.regDst   = 1'b1;
                ctrlEx.aluClass = isaPkg::CLS_FUNCT;
                ctrlWb.regWrite = 1'b1;
            end
            isaPkg::OP_ADDI: begin
                ctrlEx.aluSrc   = 1'b1;
                ctrlWb.regWrite = 1'b1;
            end
            isaPkg::OP_LW: begin
                ctrlEx.aluSrc   = 1'b1;
                ctrlMem.memRead = 1'b1;
                ctrlWb.memToReg = 1'b1;
                ctrlWb.regWrite = 1'b1;
            end
            isaPkg::OP_SW: begin
                ctrlEx.aluSrc    = 1'b1;
                ctrlMem.memWrite = 1'b1;
            end
            isaPkg::OP_BEQ: begin
                // Zero flag of rs - rt decides the branch
                ctrlEx.aluClass = isaPkg::CLS_SUB;
                ctrlMem.branch  = 1'b1;
            end
            default: begin
                // Unknown opcode stays a nop
                ctrlEx = '0;
            end
        endcase
    end

    ////////////////////
    // Writeback
    ////////////////////
    assign wbData = i_memWb.wbCtrl.memToReg ? i_memWb.loadData : i_memWb.aluResult;
    assign wbEn   = i_memWb.wbCtrl.regWrite && (i_memWb.destReg != '0);

    assign o_wbValid = wbEn;
    assign o_wbReg   = i_memWb.destReg;
    assign o_wbData  = wbData;

    always_ff @(posedge i_clk) begin
        if (wbEn) begin
            regs[i_memWb.destReg] <= wbData;
        end
    end

    // Register 0 is hardwired, a same-cycle write is passed through
    function automatic isaPkg::word_t readReg(input isaPkg::regAddr_t addr);
        isaPkg::word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wbEn && addr == i_memWb.destReg) begin
            value = wbData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // ID/EX register
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_idEx <= '0;
        end else begin
            o_idEx <= '{exCtrl: ctrlEx, memCtrl: ctrlMem, wbCtrl: ctrlWb,
                        pc4: i_ifId.pc4, rsData: readReg(rs), rtData: readReg(rt),
                        immExt: immExt, rt: rt, rd: rd};
        end
    end

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
    input  logic             i_clk,
    input  logic             i_rstN,
    input  pipePkg::idEx_t   i_idEx,
    output pipePkg::exMem_t  o_exMem
);

    isaPkg::funct_e   funct;
    isaPkg::aluOp_e   aluOp;
    isaPkg::word_t    operandA;
    isaPkg::word_t    operandB;
    isaPkg::word_t    aluResult;
    logic             zero;
    isaPkg::word_t    branchTarget;
    isaPkg::regAddr_t destReg;

    // Funct sits in the low bits of the immediate
    assign funct = isaPkg::funct_e'(i_idEx.immExt[5:0]);

    ////////////////////
    // ALU control
    ////////////////////
    always_comb begin
        case (i_idEx.exCtrl.aluClass)
            isaPkg::CLS_ADD: aluOp = isaPkg::ALU_ADD;
            isaPkg::CLS_SUB: aluOp = isaPkg::ALU_SUB;
            default: begin
                case (funct)
                    isaPkg::F_SUB: aluOp = isaPkg::ALU_SUB;
                    isaPkg::F_AND: aluOp = isaPkg::ALU_AND;
                    isaPkg::F_OR:  aluOp = isaPkg::ALU_OR;
                    isaPkg::F_SLT: aluOp = isaPkg::ALU_SLT;
                    default:       aluOp = isaPkg::ALU_ADD;
                endcase
            end
        endcase
    end

    ////////////////////
    // ALU
    ////////////////////
    assign operandA = i_idEx.rsData;
    assign operandB = i_idEx.exCtrl.aluSrc ? i_idEx.immExt : i_idEx.rtData;

    always_comb begin
        case (aluOp)
            isaPkg::ALU_SUB: aluResult = operandA - operandB;
            isaPkg::ALU_AND: aluResult = operandA & operandB;
            isaPkg::ALU_OR:  aluResult = operandA | operandB;
            isaPkg::ALU_SLT: aluResult = isaPkg::word_t'($signed(operandA) < $signed(operandB));
            default:         aluResult = operandA + operandB;
        endcase
    end

    assign zero = (aluResult == '0);

    // Offset counts words
    assign branchTarget = i_idEx.pc4 + {i_idEx.immExt[29:0], 2'b00};
    assign destReg      = i_idEx.exCtrl.regDst ? i_idEx.rd : i_idEx.rt;

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_exMem <= '0;
        end else begin
            o_exMem <= '{memCtrl: i_idEx.memCtrl, wbCtrl: i_idEx.wbCtrl,
                         branchTarget: branchTarget, zero: zero, aluResult: aluResult,
                         storeData: i_idEx.rtData, destReg: destReg};
        end
    end

endmodule

// ==== design/memoryStage.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module memoryStage (
    input  logic             i_clk,
    input  logic             i_rstN,
    input  pipePkg::exMem_t  i_exMem,
    output pipePkg::branch_t o_branch,
    output pipePkg::memWb_t  o_memWb
);

    localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

    isaPkg::word_t      dmem [`DMEM_DEPTH];
    logic [DMEM_AW-1:0] wordAddr;
    isaPkg::word_t      loadData;

    ////////////////////
    // Data memory
    ////////////////////
    assign wordAddr = i_exMem.aluResult[DMEM_AW+1:2];
    assign loadData = i_exMem.memCtrl.memRead ? dmem[wordAddr] : '0;

    always_ff @(posedge i_clk) begin
        if (i_exMem.memCtrl.memWrite) begin
            dmem[wordAddr] <= i_exMem.storeData;
        end
    end

    // Branch decision goes straight back to fetch
    assign o_branch = '{taken: i_exMem.memCtrl.branch && i_exMem.zero,
                        target: i_exMem.branchTarget};

    // MEM/WB register
    always_ff @(posedge i_clk) begin
        if (!i_rstN) begin
            o_memWb <= '0;
        end else begin
            o_memWb <= '{wbCtrl: i_exMem.wbCtrl, aluResult: i_exMem.aluResult,
                         loadData: loadData, destReg: i_exMem.destReg};
        end
    end

endmodule

// ==== design/mipsTop.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module mipsTop (
    input  logic                           i_clk,
    input  logic                           i_rstN,
    input  logic                           i_progWe,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] i_progAddr,
    input  isaPkg::word_t                  i_progData,
    output logic                           o_wbValid,
    output isaPkg::regAddr_t               o_wbReg,
    output isaPkg::word_t                  o_wbData
);

    pipePkg::ifId_t   ifId;
    pipePkg::idEx_t   idEx;
    pipePkg::exMem_t  exMem;
    pipePkg::memWb_t  memWb;
    pipePkg::branch_t branch;

    ////////////////////
    // Stages
    ////////////////////
    fetchStage fetch_i (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_branch   (branch),
        .i_progWe   (i_progWe),
        .i_progAddr (i_progAddr),
        .i_progData (i_progData),
        .o_ifId     (ifId)
    );

    decodeStage decode_i (
        .i_clk     (i_clk),
        .i_rstN    (i_rstN),
        .i_ifId    (ifId),
        .i_memWb   (memWb),
        .o_idEx    (idEx),
        .o_wbValid (o_wbValid),
        .o_wbReg   (o_wbReg),
        .o_wbData  (o_wbData)
    );

    executeStage execute_i (
        .i_clk   (i_clk),
        .i_rstN  (i_rstN),
        .i_idEx  (idEx),
        .o_exMem (exMem)
    );

    memoryStage memory_i (
        .i_clk    (i_clk),
        .i_rstN   (i_rstN),
        .i_exMem  (exMem),
        .o_branch (branch),
        .o_memWb  (memWb)
    );

endmodule

// ==== verification/mips_assert.sv ====
`timescale 1ns/100ps

module mipsAssert (
    input logic             i_clk,
    input logic             i_rstN,
    input logic             i_wbValid,
    input isaPkg::regAddr_t i_wbReg,
    input isaPkg::word_t    i_pc
);

    int   failCount = 0;
    int   cyclesOut = 0;
    logic resetSeen = 1'b0;

    // Cycles since reset was released, saturating
    always @(posedge i_clk) begin
        if (!i_rstN) begin
            cyclesOut <= 0;
            resetSeen <= 1'b1;
        end else if (cyclesOut < 8) begin
            cyclesOut <= cyclesOut + 1;
        end
    end

    ////////////////////
    // Writeback port
    ////////////////////

    // Four stages ahead of writeback, nothing retires earlier
    earlyWriteback: assert property (@(posedge i_clk)
        (resetSeen && (!i_rstN || cyclesOut < 4)) |-> !i_wbValid)
        else begin
            failCount++;
            $error("Writeback strobe high during reset or before the pipeline filled");
        end

    zeroRegWrite: assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_wbValid |-> (i_wbReg != '0))
        else begin
            failCount++;
            $error("Writeback strobe high for register 0");
        end

    ////////////////////
    // Fetch
    ////////////////////
    pcAligned: assert property (@(posedge i_clk) disable iff (!i_rstN)
        i_pc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("Fetch PC %h is not word aligned", i_pc);
        end

endmodule

bind mipsTop mipsAssert assertChecks_i (
    .i_clk     (i_clk),
    .i_rstN    (i_rstN),
    .i_wbValid (o_wbValid),
    .i_wbReg   (o_wbReg),
    .i_pc      (fetch_i.pc)
);

// ==== verification/mipsChecker.sv ====
`timescale 1ns/100ps

module mipsChecker (
    input  logic             i_clk,
    input  logic             i_rstN,
    input  logic             i_wbValid,
    input  isaPkg::regAddr_t i_wbReg,
    input  isaPkg::word_t    i_wbData,
    output int               o_mismatchCount,
    output int               o_extraCount,
    output int               o_pendingCount
);

    // One expected register write
    typedef struct packed {
        isaPkg::regAddr_t regNum;
        isaPkg::word_t    data;
    } wbWrite_t;

    string    expName[$];
    wbWrite_t expWrite[$];

    // Appends to the list in writeback order
    task automatic addExpect(input string name, input int regNum, input isaPkg::word_t data);
        expName.push_back(name);
        expWrite.push_back('{regNum: isaPkg::regAddr_t'(regNum), data: data});
        o_pendingCount = expName.size();
    endtask

    task automatic checkWrite(input isaPkg::regAddr_t regNum, input isaPkg::word_t data);
        string    name;
        wbWrite_t expected;
        if (expName.size() == 0) begin
            o_extraCount++;
            $display("Error: extra register write occurred, r%0d = %h", regNum, data);
        end else begin
            name     = expName.pop_front();
            expected = expWrite.pop_front();
            o_pendingCount = expName.size();
            if (regNum !== expected.regNum || data !== expected.data) begin
                o_mismatchCount++;
                $display("Mismatch in %s: expected r%0d = %h, actual r%0d = %h",
                         name, expected.regNum, expected.data, regNum, data);
            end
        end
    endtask

    task automatic reportMissing();
        if (expName.size() > 0) begin
            $display("Error: %0d expected register writes never occurred, first missing in %s",
                     expName.size(), expName[0]);
        end
    endtask

    ////////////////////
    // Writeback monitor
    ////////////////////

    // Port values of the cycle that ends at this edge
    always @(posedge i_clk) begin
        if (i_rstN === 1'b1 && i_wbValid === 1'b1) begin
            checkWrite(i_wbReg, i_wbData);
        end
    end

endmodule

// ==== verification/mipsTb.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module mipsTb;

    localparam int IMEM_AW      = $clog2(`IMEM_DEPTH);
    localparam int RESET_CYCLES = 5;
    localparam int SLACK_CYCLES = 20;
    localparam int DRAIN_CYCLES = 8;

    logic               clk;
    logic               rstN;
    logic               progWe;
    logic [IMEM_AW-1:0] progAddr;
    isaPkg::word_t      progData;
    logic               wbValid;
    isaPkg::regAddr_t   wbReg;
    isaPkg::word_t      wbData;

    int            mismatchCount;
    int            extraCount;
    int            pendingCount;
    int            loadErrors;
    int            timeoutErrors;
    int            assertErrors;
    int            totalErrors;
    int            cycleCount;
    int            cycleLimit;
    int            seedValue;
    int            progIndex[$];
    isaPkg::word_t progWord[$];

    mipsTop dut_i (
        .i_clk      (clk),
        .i_rstN     (rstN),
        .i_progWe   (progWe),
        .i_progAddr (progAddr),
        .i_progData (progData),
        .o_wbValid  (wbValid),
        .o_wbReg    (wbReg),
        .o_wbData   (wbData)
    );

    mipsChecker checker_i (
        .i_clk           (clk),
        .i_rstN          (rstN),
        .i_wbValid       (wbValid),
        .i_wbReg         (wbReg),
        .i_wbData        (wbData),
        .o_mismatchCount (mismatchCount),
        .o_extraCount    (extraCount),
        .o_pendingCount  (pendingCount)
    );

    always #50 clk = ~clk;

    // Run length, counted from reset release
    always @(posedge clk) begin
        if (rstN) begin
            cycleCount <= cycleCount + 1;
        end
    end

    ////////////////////
    // Stimulus file
    ////////////////////
    task automatic readStimulus();
        int            fd;
        int            lineNum;
        int            addr;
        int            regNum;
        int            expectCount;
        isaPkg::word_t value;
        string         line;
        string         tag;
        string         name;
        lineNum     = 0;
        expectCount = 0;
        fd = $fopen("verification/program_input.txt", "r");
        if (fd == 0) begin
            loadErrors++;
            $display("Error: could not open verification/program_input.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            lineNum++;
            if ($sscanf(line, "%s", tag) != 1 || tag.substr(0, 0) == "#") begin
                continue;
            end
            if (tag == "P" && $sscanf(line, "%s %h %h", tag, addr, value) == 3
                && addr < `IMEM_DEPTH) begin
                progIndex.push_back(addr);
                progWord.push_back(value);
            end else if (tag == "E"
                         && $sscanf(line, "%s %s %d %h", tag, name, regNum, value) == 4) begin
                checker_i.addExpect(name, regNum, value);
                expectCount++;
            end else begin
                loadErrors++;
                $display("Error: stimulus file line %0d could not be read", lineNum);
            end
        end
        $fclose(fd);
        if (progWord.size() == 0 || expectCount == 0) begin
            loadErrors++;
            $display("Error: stimulus file holds no program or no expected writes");
        end
    endtask

    // One word per falling edge, core held in reset
    task automatic loadProgram();
        for (int i = 0; i < progWord.size(); i++) begin
            @(negedge clk);
            progWe   = 1'b1;
            progAddr = progIndex[i][IMEM_AW-1:0];
            progData = progWord[i];
        end
        @(negedge clk);
        progWe   = 1'b0;
        progData = $urandom();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        seedValue = $urandom(32'hf165);
        clk       = 1'b0;
        rstN      = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        readStimulus();
        cycleLimit = progWord.size() + SLACK_CYCLES;
        loadProgram();
        // Reset stays low through the load, then five cycles more
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            progData = $urandom();
        end
        rstN = 1'b1;
        while (pendingCount > 0 && cycleCount < cycleLimit) begin
            @(negedge clk);
            progData = $urandom();
        end
        if (pendingCount > 0) begin
            timeoutErrors++;
            $display("Error: run timed out after %0d cycles", cycleCount);
        end else begin
            // Room for any stray write after the last expected one
            repeat (DRAIN_CYCLES) begin
                @(negedge clk);
                progData = $urandom();
            end
        end
        checker_i.reportMissing();
        assertErrors = dut_i.assertChecks_i.failCount;
        totalErrors  = mismatchCount + extraCount + pendingCount + timeoutErrors
                     + loadErrors + assertErrors;
        $display("Errors: mismatch %0d, extra %0d, missing %0d, timeout %0d, load %0d, assert %0d",
                 mismatchCount, extraCount, pendingCount, timeoutErrors, loadErrors,
                 assertErrors);
        if (totalErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verification/program_input.txt ====
# P <word address hex> <instruction hex>
# E <test name> <register decimal> <expected writeback value hex>
# Seeds, then filler
P 00 20010007
P 01 2003000C
P 02 2002FFFD
P 03 00000000
# Immediate add, negative immediates
P 04 202BFFF8
P 05 202CFFF1
# R-type
P 06 00232820
P 07 00233022
P 08 00233824
P 09 00234025
P 0a 0041482A
P 0b 0022502A
# Store then load
P 0c AC010008
P 0d AC06000C
P 0e AC650008
P 0f 8C0D0008
P 10 8C0E000C
P 11 8C0F0014
# Register zero
P 12 20200005
P 13 00210020
P 14 00000000
P 15 00000000
P 16 00018020
# Branch not taken
P 17 10220005
P 18 20110011
P 19 20120012
P 1a 20130013
P 1b 20140014
# Branch taken to word 0x23
P 1c 11A10006
P 1d 20150021
P 1e 20160022
P 1f 20170023
P 20 20180066
P 21 20190066
P 22 201A0066
P 23 201B0035
P 24 01AEE025
P 25 00000000
P 26 00000000
P 27 00000000
# Expected writebacks in order
E seed_r1 1 00000007
E seed_r3 3 0000000C
E seed_r2 2 FFFFFFFD
E addi_neg 11 FFFFFFFF
E addi_neg 12 FFFFFFF8
E rtype_add 5 00000013
E rtype_sub 6 FFFFFFFB
E rtype_and 7 00000004
E rtype_or 8 0000000F
E slt_true 9 00000001
E slt_false 10 00000000
E load_word2 13 00000007
E load_word3 14 FFFFFFFB
E load_word5 15 00000013
E reg_zero 16 00000007
E not_taken 17 00000011
E not_taken 18 00000012
E not_taken 19 00000013
E not_taken 20 00000014
E taken_shadow 21 00000021
E taken_shadow 22 00000022
E taken_shadow 23 00000023
E taken_target 27 00000035
E taken_target 28 FFFFFFFF

// ==== all.f ====
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsTop.sv
verification/mips_assert.sv
verification/mipsChecker.sv
verification/mipsTb.sv
